// ==== design/alu_pkg.sv ====
package alu_pkg;

  localparam int data_w = 32;
  localparam int op_w   = 12;

  // one-hot op code bit positions
  localparam int op_add  = 0;
  localparam int op_sub  = 1;
  localparam int op_slt  = 2;   // signed compare
  localparam int op_sltu = 3;   // unsigned compare
  localparam int op_and  = 4;
  localparam int op_nor  = 5;
  localparam int op_or   = 6;
  localparam int op_xor  = 7;
  localparam int op_sll  = 8;
  localparam int op_srl  = 9;
  localparam int op_sra  = 10;
  localparam int op_lui  = 11;  // passes src2

  // result fifo sizing
  localparam int fifo_depth = 8;
  localparam int count_w    = 4;  // holds 0..fifo_depth
  localparam int ptr_w      = 3;

  localparam int addr_w = 8;

  // register map
  localparam logic [addr_w-1:0] reg_src1   = 8'h00;
  localparam logic [addr_w-1:0] reg_src2   = 8'h04;
  localparam logic [addr_w-1:0] reg_op     = 8'h08;
  localparam logic [addr_w-1:0] reg_go     = 8'h0C;  // write only
  localparam logic [addr_w-1:0] reg_result = 8'h10;  // read only, pops
  localparam logic [addr_w-1:0] reg_status = 8'h14;  // read only

endpackage

// ==== design/alu_cmd_if.sv ====
interface alu_cmd_if;
  import alu_pkg::*;

  logic              valid;
  logic              ready;
  logic [op_w-1:0]   op;
  logic [data_w-1:0] src1;
  logic [data_w-1:0] src2;

  // register block side
  modport src (
    output valid, op, src1, src2,
    input  ready
  );

  // pipeline side
  modport dst (
    input  valid, op, src1, src2,
    output ready
  );

endinterface

// ==== design/alu_res_if.sv ====
interface alu_res_if;
  import alu_pkg::*;

  logic               pop;
  logic [data_w-1:0]  data;   // head entry
  logic               empty;
  logic [count_w-1:0] count;

  // register block pops results
  modport rd (
    output pop,
    input  data, empty, count
  );

  modport fifo (
    input  pop,
    output data, empty, count
  );

endinterface

// ==== design/alu.sv ====
module alu (
  input  logic [alu_pkg::op_w-1:0]   op,
  input  logic [alu_pkg::data_w-1:0] src1,
  input  logic [alu_pkg::data_w-1:0] src2,
  output logic [alu_pkg::data_w-1:0] result
);
  import alu_pkg::*;

  localparam int sh_w = $clog2(data_w);

  logic [data_w-1:0] add_res;
  logic [data_w-1:0] diff;
  logic              carry;
  logic              slt_bit;
  logic              sltu_bit;
  logic [data_w-1:0] and_res;
  logic [data_w-1:0] or_res;
  logic [data_w-1:0] nor_res;
  logic [data_w-1:0] xor_res;
  logic [sh_w-1:0]   shamt;
  logic [data_w-1:0] sll_res;
  logic [data_w-1:0] srl_res;
  logic [data_w-1:0] sra_res;

  assign add_res = src1 + src2;

  // shared subtractor for sub, slt and sltu
  assign {carry, diff} = {1'b0, src1} + {1'b0, ~src2} + 1'b1;

  // signs differ means src1 negative wins, else look at the difference
  assign slt_bit = (src1[data_w-1] & ~src2[data_w-1])
                 | ((src1[data_w-1] ~^ src2[data_w-1]) & diff[data_w-1]);
  assign sltu_bit = ~carry;  // borrow out

  assign and_res = src1 & src2;
  assign or_res  = src1 | src2;
  assign nor_res = ~or_res;
  assign xor_res = src1 ^ src2;

  assign shamt   = src2[sh_w-1:0];
  assign sll_res = src1 << shamt;
  assign srl_res = src1 >> shamt;
  assign sra_res = $signed(src1) >>> shamt;

  // and-or mux, several op bits OR their results together
  assign result = ({data_w{op[op_add]}}  & add_res)
                | ({data_w{op[op_sub]}}  & diff)
                | ({data_w{op[op_slt]}}  & data_w'(slt_bit))
                | ({data_w{op[op_sltu]}} & data_w'(sltu_bit))
                | ({data_w{op[op_and]}}  & and_res)
                | ({data_w{op[op_nor]}}  & nor_res)
                | ({data_w{op[op_or]}}   & or_res)
                | ({data_w{op[op_xor]}}  & xor_res)
                | ({data_w{op[op_sll]}}  & sll_res)
                | ({data_w{op[op_srl]}}  & srl_res)
                | ({data_w{op[op_sra]}}  & sra_res)
                | ({data_w{op[op_lui]}}  & src2);

endmodule

// ==== design/alu_exec.sv ====
module alu_exec (
  input  logic                       clk,
  input  logic                       rst,
  alu_cmd_if.dst                     cmd,
  output logic                       push,
  output logic [alu_pkg::data_w-1:0] push_data,
  input  logic                       full
);
  import alu_pkg::*;

  logic              s1_valid;
  logic [op_w-1:0]   s1_op;
  logic [data_w-1:0] s1_src1;
  logic [data_w-1:0] s1_src2;
  logic              s2_valid;
  logic [data_w-1:0] s2_result;
  logic [data_w-1:0] alu_out;
  logic              s2_free;   // stage 2 can take a new result
  logic              s1_move;
  logic              accept;

  alu u_alu (
    .op     (s1_op),
    .src1   (s1_src1),
    .src2   (s1_src2),
    .result (alu_out)
  );

  assign push      = s2_valid & ~full;
  assign push_data = s2_result;
  assign s2_free   = ~s2_valid | push;
  assign s1_move   = s1_valid & s2_free;
  assign cmd.ready = ~s1_valid | s2_free;
  assign accept    = cmd.valid & cmd.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (accept) s1_valid <= 1'b1;
      else if (s1_move) s1_valid <= 1'b0;
      if (s2_free) s2_valid <= s1_valid;  // fills or drains
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s1_op   <= cmd.op;
      s1_src1 <= cmd.src1;
      s1_src2 <= cmd.src2;
    end
    if (s1_move) s2_result <= alu_out;
  end

  // a stalled result must not change under back-pressure
  a_s2_hold: assert property (@(posedge clk) disable iff (rst)
    s2_valid && !push |=> s2_valid && $stable(s2_result));

endmodule

// ==== design/alu_result_fifo.sv ====
module alu_result_fifo (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       push,
  input  logic [alu_pkg::data_w-1:0] push_data,
  output logic                       full,
  alu_res_if.fifo                    rd
);
  import alu_pkg::*;

  logic [data_w-1:0]  mem [fifo_depth];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [count_w-1:0] count_q;

  assign full     = count_q == count_w'(fifo_depth);
  assign rd.empty = count_q == '0;
  assign rd.count = count_q;
  assign rd.data  = mem[rd_ptr];  // head entry

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end else begin
      // pointers wrap, depth is a power of two
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (rd.pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, rd.pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // idle or push with pop
      endcase
    end
  end

  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) rd.pop |-> !rd.empty);

  a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full);

endmodule

// ==== design/alu_apb_regs.sv ====
module alu_apb_regs (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [alu_pkg::addr_w-1:0] paddr,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [alu_pkg::data_w-1:0] pwdata,
  output logic [alu_pkg::data_w-1:0] prdata,
  output logic                       pready,
  output logic                       pslverr,
  alu_cmd_if.src                     cmd,
  alu_res_if.rd                      rd
);
  import alu_pkg::*;

  logic              access;
  logic              wr_acc;
  logic              rd_acc;
  logic [data_w-1:0] src1_q;
  logic [data_w-1:0] src2_q;
  logic [op_w-1:0]   op_q;

  assign access = psel & penable;  // apb access phase
  assign wr_acc = access & pwrite;
  assign rd_acc = access & ~pwrite;
  assign pready = 1'b1;  // no wait states

  // one cycle command that is dropped when the pipeline is not ready
  assign cmd.valid = wr_acc && (paddr == reg_go);
  assign cmd.op    = op_q;
  assign cmd.src1  = src1_q;
  assign cmd.src2  = src2_q;

  assign rd.pop = rd_acc && (paddr == reg_result) && !rd.empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      src1_q <= '0;
      src2_q <= '0;
      op_q   <= '0;
    end else if (wr_acc) begin
      case (paddr)
        reg_src1: src1_q <= pwdata;
        reg_src2: src2_q <= pwdata;
        reg_op:   op_q   <= pwdata[op_w-1:0];
        default:  ;
      endcase
    end
  end

  always_comb begin
    prdata  = '0;
    pslverr = 1'b0;
    if (access) begin
      case (paddr)
        reg_src1: if (!pwrite) prdata = src1_q;
        reg_src2: if (!pwrite) prdata = src2_q;
        reg_op:   if (!pwrite) prdata = data_w'(op_q);
        reg_go:   pslverr = !pwrite || !cmd.ready;
        reg_result: begin
          if (pwrite || rd.empty) pslverr = 1'b1;
          else prdata = rd.data;
        end
        reg_status: begin
          if (pwrite) pslverr = 1'b1;
          else prdata = data_w'(rd.count);  // fill count
        end
        default:  pslverr = 1'b1;  // unmapped
      endcase
    end
  end

  // go pulse never lasts two cycles
  a_cmd_one_shot: assert property (@(posedge clk) disable iff (rst)
    cmd.valid |=> !cmd.valid);

endmodule

// ==== design/alu_apb_top.sv ====
module alu_apb_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [alu_pkg::addr_w-1:0] paddr,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [alu_pkg::data_w-1:0] pwdata,
  output logic [alu_pkg::data_w-1:0] prdata,
  output logic                       pready,
  output logic                       pslverr
);
  import alu_pkg::*;

  logic              push;
  logic [data_w-1:0] push_data;
  logic              full;

  alu_cmd_if cmd_if ();
  alu_res_if res_if ();

  alu_apb_regs u_regs (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .cmd     (cmd_if),
    .rd      (res_if)
  );

  alu_exec u_exec (
    .clk       (clk),
    .rst       (rst),
    .cmd       (cmd_if),
    .push      (push),
    .push_data (push_data),
    .full      (full)
  );

  alu_result_fifo u_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .push_data (push_data),
    .full      (full),
    .rd        (res_if)
  );

endmodule

// ==== test/alu_tb.sv ====
module alu_tb;
  import alu_pkg::*;

  logic              clk;
  logic              rst;
  logic [addr_w-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [data_w-1:0] pwdata;
  logic [data_w-1:0] prdata;
  logic              pready;
  logic              pslverr;

  logic [data_w-1:0] exp_q [$];  // results the DUT still owes in issue order
  logic [data_w-1:0] cur_src1;
  logic [data_w-1:0] cur_src2;
  logic [op_w-1:0]   cur_op;
  int                checks;
  int                errors;

  alu_apb_top u_alu_apb_top (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #2 clk = ~clk;

  // reference ALU that ORs every selected op into the result
  function automatic logic [data_w-1:0] alu_model(input logic [op_w-1:0] op,
      input logic [data_w-1:0] a, input logic [data_w-1:0] b);
    logic [data_w-1:0] r;
    logic [data_w-1:0] sra_v;
    logic [4:0]        sh;
    r     = '0;
    sh    = b[4:0];
    sra_v = $signed(a) >>> sh;  // sign fill
    if (op[op_add])  r = r | (a + b);
    if (op[op_sub])  r = r | (a - b);
    if (op[op_slt])  r = r | {31'd0, $signed(a) < $signed(b)};
    if (op[op_sltu]) r = r | {31'd0, a < b};
    if (op[op_and])  r = r | (a & b);
    if (op[op_nor])  r = r | ~(a | b);
    if (op[op_or])   r = r | (a | b);
    if (op[op_xor])  r = r | (a ^ b);
    if (op[op_sll])  r = r | (a << sh);
    if (op[op_srl])  r = r | (a >> sh);
    if (op[op_sra])  r = r | sra_v;
    if (op[op_lui])  r = r | b;
    return r;
  endfunction

  task automatic abort_run(input string what);
    errors++;
    $display("%s", what);
    $display("checks %0d, errors %0d", checks, errors);
    $display("Testbench failed");
    $finish;
  endtask

  task automatic check(input string name, input logic [data_w-1:0] got,
                       input logic [data_w-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // one APB transfer with setup and access phase
  task automatic bus_access(input logic wr, input logic [addr_w-1:0] addr,
      input logic [data_w-1:0] wdata, output logic [data_w-1:0] rdata, output logic err);
    int waits;
    waits = 0;
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);  // outputs settled mid cycle
    while (!pready && waits < 20) begin
      @(negedge clk);
      waits++;
    end
    if (!pready) abort_run($sformatf("timeout: pready never rose at address 0x%h", addr));
    else begin
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
    end
  endtask

  task automatic apb_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                           output logic err);
    logic [data_w-1:0] unused;
    bus_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data,
                          output logic err);
    bus_access(1'b0, addr, '0, data, err);
  endtask

  // write and track the operand and op registers
  task automatic write_reg(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
    logic err;
    apb_write(addr, data, err);
    check("pslverr", data_w'(err), 32'd0);
    if (addr == reg_src1) cur_src1 = data;
    if (addr == reg_src2) cur_src2 = data;
    if (addr == reg_op) cur_op = data[op_w-1:0];
  endtask

  task automatic set_operands(input logic [data_w-1:0] a, input logic [data_w-1:0] b,
                              input logic [op_w-1:0] op);
    write_reg(reg_src1, a);
    write_reg(reg_src2, b);
    write_reg(reg_op, data_w'(op));
  endtask

  task automatic issue_go(output logic accepted);
    logic err;
    apb_write(reg_go, '0, err);
    accepted = !err;
    if (accepted) exp_q.push_back(alu_model(cur_op, cur_src1, cur_src2));
  endtask

  // poll STATUS until the fill count reaches the expected value
  task automatic wait_count(input int expected);
    logic [data_w-1:0] d;
    logic              err;
    int                polls;
    polls = 0;
    apb_read(reg_status, d, err);
    while (d != data_w'(expected) && polls < 20) begin
      apb_read(reg_status, d, err);
      polls++;
    end
    if (d != data_w'(expected))
      abort_run($sformatf("timeout: fill count stuck at %0d, waiting for %0d", d, expected));
  endtask

  task automatic pop_check();
    logic [data_w-1:0] d;
    logic              err;
    apb_read(reg_result, d, err);
    check("result pslverr", data_w'(err), 32'd0);
    check("prdata", d, exp_q.pop_front());
  endtask

  task automatic drain_results();
    while (exp_q.size() > 0) begin
      wait_count(exp_q.size() > fifo_depth ? fifo_depth : exp_q.size());
      pop_check();
    end
  endtask

  task automatic run_one(input logic [op_w-1:0] op, input logic [data_w-1:0] a,
                         input logic [data_w-1:0] b);
    logic [data_w-1:0] d;
    logic              err;
    logic              accepted;
    set_operands(a, b, op);
    apb_read(reg_src1, d, err);
    check("src1", d, a);
    apb_read(reg_src2, d, err);
    check("src2", d, b);
    apb_read(reg_op, d, err);
    check("op", d, data_w'(op));
    issue_go(accepted);
    check("go accepted", data_w'(accepted), 32'd1);
    wait_count(exp_q.size());
    pop_check();
  endtask

  initial begin
    logic [data_w-1:0] corners [3];
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic [data_w-1:0] d;
    logic              err;
    logic              accepted;
    int                n_acc;
    int                sel;
    void'($urandom(54));
    clk      = 1'b0;
    rst      = 1'b1;
    paddr    = '0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    pwdata   = '0;
    cur_src1 = '0;
    cur_src2 = '0;
    cur_op   = '0;
    checks   = 0;
    errors   = 0;
    corners  = '{32'h0000_0000, 32'h8000_0000, 32'hffff_ffff};
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;

    // single ops on corner pairs then random operands
    for (int i = 0; i < op_w; i++) begin
      for (int k = 0; k < 6; k++) begin
        a = (k < 3) ? corners[k] : $urandom;
        b = (k < 3) ? corners[(k + 1) % 3] : $urandom;
        run_one(op_w'(1) << i, a, b);
      end
    end

    for (int k = 0; k < 30; k++) run_one(op_w'($urandom), $urandom, $urandom);
    run_one('0, $urandom, $urandom);

    // no reads until the pipeline and FIFO back up
    n_acc = 0;
    for (int k = 0; k < fifo_depth + 4; k++) begin
      set_operands($urandom, $urandom, op_w'(1) << op_xor);
      issue_go(accepted);
      if (accepted) n_acc++;
      check("go pslverr", data_w'(!accepted), data_w'(k >= fifo_depth + 2));
    end
    check("accepted gos", data_w'(n_acc), data_w'(fifo_depth + 2));
    wait_count(fifo_depth);
    drain_results();

    // error responses
    apb_read(reg_result, d, err);
    check("empty pslverr", data_w'(err), 32'd1);
    check("empty prdata", d, '0);
    apb_read(8'h20, d, err);
    check("unmapped pslverr", data_w'(err), 32'd1);
    apb_write(reg_status, 32'h1, err);
    check("status write pslverr", data_w'(err), 32'd1);
    apb_read(reg_go, d, err);
    check("go read pslverr", data_w'(err), 32'd1);

    // mixed traffic
    for (int k = 0; k < 300; k++) begin
      sel = $urandom % 5;
      if (sel == 0) write_reg(reg_src1, $urandom);
      else if (sel == 1) write_reg(reg_src2, $urandom);
      else if (sel == 2) write_reg(reg_op, data_w'(op_w'($urandom)));
      else if (sel == 3 && exp_q.size() < fifo_depth) begin
        issue_go(accepted);
        check("go accepted", data_w'(accepted), 32'd1);
      end else if (exp_q.size() == 0) begin
        apb_read(reg_result, d, err);
        check("empty pslverr", data_w'(err), 32'd1);
        check("empty prdata", d, '0);
      end else begin
        wait_count(exp_q.size());
        pop_check();
      end
    end
    drain_results();
    wait_count(0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) $display("Testbench passed");
    else $display("Testbench failed");
    $finish;
  end

endmodule

// ==== build.f ====
design/alu_pkg.sv
design/alu_cmd_if.sv
design/alu_res_if.sv
design/alu.sv
design/alu_exec.sv
design/alu_result_fifo.sv
design/alu_apb_regs.sv
design/alu_apb_top.sv
test/alu_tb.sv

// ==== Makefile ====
TOP = alu_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
